/* rtl/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define DEC_XLEN        32
`define DEC_RADDR_W     5
`define DEC_NREGS       32
`define DEC_LINK_REG    5'd31

// primary opcode field, inst[31:26]
`define DEC_OP_SPECIAL  6'h00
`define DEC_OP_J        6'h02
`define DEC_OP_JAL      6'h03
`define DEC_OP_BEQ      6'h04
`define DEC_OP_BNE      6'h05
`define DEC_OP_ADDIU    6'h09
`define DEC_OP_LUI      6'h0f
`define DEC_OP_LW       6'h23
`define DEC_OP_SW       6'h2b

// function field for SPECIAL, inst[5:0]
`define DEC_FN_SLL      6'h00
`define DEC_FN_SRL      6'h02
`define DEC_FN_SRA      6'h03
`define DEC_FN_JR       6'h08
`define DEC_FN_ADDU     6'h21
`define DEC_FN_SUBU     6'h23
`define DEC_FN_AND      6'h24
`define DEC_FN_OR       6'h25
`define DEC_FN_XOR      6'h26
`define DEC_FN_NOR      6'h27
`define DEC_FN_SLT      6'h2a
`define DEC_FN_SLTU     6'h2b

`endif

/* rtl/decode_pkg.sv */
`include "decode_consts.svh"

package decode_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_J,
        BR_JAL,
        BR_JR
    } br_kind_e;

    typedef struct packed {
        logic [`DEC_XLEN-1:0] pc;
        logic [`DEC_XLEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                    we;
        logic [`DEC_RADDR_W-1:0] addr;
        logic [`DEC_XLEN-1:0]    data;
    } wb_write_t;

    // result of a later stage, seen by the bypass
    typedef struct packed {
        logic                    wen;
        logic                    is_load;
        logic [`DEC_RADDR_W-1:0] dest;
        logic [`DEC_XLEN-1:0]    value;
    } fwd_src_t;

    typedef struct packed {
        alu_op_e                 alu_op;
        br_kind_e                br_kind;
        logic                    src1_is_sa;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    src2_is_8;
        logic                    res_from_mem;
        logic                    gr_we;
        logic                    mem_we;
        logic [`DEC_RADDR_W-1:0] dest;
        logic [15:0]             imm;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    src1_is_sa;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    src2_is_8;
        logic                    res_from_mem;
        logic                    gr_we;
        logic                    mem_we;
        logic [`DEC_RADDR_W-1:0] dest;
        logic [15:0]             imm;
        logic [`DEC_RADDR_W-1:0] sa;
        logic [`DEC_XLEN-1:0]    rs_value;
        logic [`DEC_XLEN-1:0]    rt_value;
        logic [`DEC_XLEN-1:0]    pc;
    } issue_pkt_t;

    typedef struct packed {
        logic                 taken;
        logic [`DEC_XLEN-1:0] target;
    } redirect_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module inst_decoder import decode_pkg::*; (
    input  logic [`DEC_XLEN-1:0] inst,
    output dec_ctrl_t            ctrl
);

    logic [5:0]              op;
    logic [5:0]              func;
    logic [`DEC_RADDR_W-1:0] rs;
    logic [`DEC_RADDR_W-1:0] rt;
    logic [`DEC_RADDR_W-1:0] rd;
    logic [`DEC_RADDR_W-1:0] sa;

    logic    fn_known;  // func is one of the register alu ops
    logic    fn_shift;  // sll/srl/sra, rs field must be zero
    alu_op_e fn_op;
    logic    is_alu_r;
    logic    is_jr;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    ////////////////////////////////////////////////////////////////////////////
    // SPECIAL function field
    always_comb begin
        fn_known = 1'b1;
        fn_shift = 1'b0;
        fn_op    = ALU_ADD;
        case (func)
            `DEC_FN_ADDU: fn_op = ALU_ADD;
            `DEC_FN_SUBU: fn_op = ALU_SUB;
            `DEC_FN_SLT:  fn_op = ALU_SLT;
            `DEC_FN_SLTU: fn_op = ALU_SLTU;
            `DEC_FN_AND:  fn_op = ALU_AND;
            `DEC_FN_OR:   fn_op = ALU_OR;
            `DEC_FN_XOR:  fn_op = ALU_XOR;
            `DEC_FN_NOR:  fn_op = ALU_NOR;
            `DEC_FN_SLL: begin
                fn_op    = ALU_SLL;
                fn_shift = 1'b1;
            end
            `DEC_FN_SRL: begin
                fn_op    = ALU_SRL;
                fn_shift = 1'b1;
            end
            `DEC_FN_SRA: begin
                fn_op    = ALU_SRA;
                fn_shift = 1'b1;
            end
            default: fn_known = 1'b0;
        endcase
    end

    // unused fields have to be zero
    assign is_alu_r = (op == `DEC_OP_SPECIAL) && fn_known &&
                      (fn_shift ? (rs == '0) : (sa == '0));
    assign is_jr    = (op == `DEC_OP_SPECIAL) && (func == `DEC_FN_JR) &&
                      (rt == '0) && (rd == '0) && (sa == '0);

    ////////////////////////////////////////////////////////////////////////////
    // control fields
    always_comb begin
        ctrl         = '0;          // anything unmatched is a no-op
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_kind = BR_NONE;
        ctrl.dest    = rd;
        ctrl.imm     = inst[15:0];
        if (is_alu_r) begin
            ctrl.alu_op     = fn_op;
            ctrl.src1_is_sa = fn_shift;
            ctrl.gr_we      = 1'b1;
        end
        if (is_jr) begin
            ctrl.br_kind = BR_JR;
        end
        case (op)
            `DEC_OP_ADDIU: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.gr_we       = 1'b1;
                ctrl.dest        = rt;
            end
            `DEC_OP_LUI: begin
                if (rs == '0) begin
                    ctrl.alu_op      = ALU_LUI;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.gr_we       = 1'b1;
                    ctrl.dest        = rt;
                end
            end
            `DEC_OP_LW: begin
                ctrl.src2_is_imm  = 1'b1;
                ctrl.res_from_mem = 1'b1;
                ctrl.gr_we        = 1'b1;
                ctrl.dest         = rt;
            end
            `DEC_OP_SW: begin
                ctrl.src2_is_imm = 1'b1;    // address = rs + imm
                ctrl.mem_we      = 1'b1;
            end
            `DEC_OP_BEQ: ctrl.br_kind = BR_BEQ;
            `DEC_OP_BNE: ctrl.br_kind = BR_BNE;
            `DEC_OP_J:   ctrl.br_kind = BR_J;
            `DEC_OP_JAL: begin
                ctrl.br_kind    = BR_JAL;
                ctrl.src1_is_pc = 1'b1;     // link value pc + 8
                ctrl.src2_is_8  = 1'b1;
                ctrl.gr_we      = 1'b1;
                ctrl.dest       = `DEC_LINK_REG;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module regfile import decode_pkg::*; (
    input  logic                    clk,
    input  logic [`DEC_RADDR_W-1:0] raddr1,
    output logic [`DEC_XLEN-1:0]    rdata1,
    input  logic [`DEC_RADDR_W-1:0] raddr2,
    output logic [`DEC_XLEN-1:0]    rdata2,
    input  wb_write_t               wr
);

    logic [`DEC_XLEN-1:0] regs [`DEC_NREGS];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired, whatever was written to it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module operand_bypass import decode_pkg::*; (
    input  logic [`DEC_RADDR_W-1:0] rs,
    input  logic [`DEC_RADDR_W-1:0] rt,
    input  logic [`DEC_XLEN-1:0]    rf_rdata1,
    input  logic [`DEC_XLEN-1:0]    rf_rdata2,
    input  fwd_src_t                es_fwd,
    input  fwd_src_t                ms_fwd,
    input  fwd_src_t                ws_fwd,
    output logic [`DEC_XLEN-1:0]    rs_value,
    output logic [`DEC_XLEN-1:0]    rt_value,
    output logic                    stall
);

    // source writes a nonzero register equal to r
    function automatic logic hit(input fwd_src_t src, input logic [`DEC_RADDR_W-1:0] r);
        return src.wen && (src.dest != '0) && (src.dest == r);
    endfunction

    logic es_rs, ms_rs, ws_rs;
    logic es_rt, ms_rt, ws_rt;

    assign es_rs = hit(es_fwd, rs);
    assign ms_rs = hit(ms_fwd, rs);
    assign ws_rs = hit(ws_fwd, rs);
    assign es_rt = hit(es_fwd, rt);
    assign ms_rt = hit(ms_fwd, rt);
    assign ws_rt = hit(ws_fwd, rt);

    // youngest result wins
    assign rs_value = es_rs ? es_fwd.value :
                      ms_rs ? ms_fwd.value :
                      ws_rs ? ws_fwd.value :
                              rf_rdata1;
    assign rt_value = es_rt ? es_fwd.value :
                      ms_rt ? ms_fwd.value :
                      ws_rt ? ws_fwd.value :
                              rf_rdata2;

    // load data not there yet in es or ms
    assign stall = (es_fwd.is_load && (es_rs || es_rt)) ||
                   (ms_fwd.is_load && (ms_rs || ms_rt));

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module branch_unit import decode_pkg::*; (
    input  br_kind_e             br_kind,
    input  logic [`DEC_XLEN-1:0] pc,
    input  logic [`DEC_XLEN-1:0] rs_value,
    input  logic [`DEC_XLEN-1:0] rt_value,
    input  logic [15:0]          imm,
    input  logic [25:0]          jidx,
    input  logic                 fire,
    output redirect_t            redirect
);

    logic [`DEC_XLEN-1:0] pc_plus4;
    logic [`DEC_XLEN-1:0] br_offset;
    logic                 rs_eq_rt;
    logic                 cond;

    assign pc_plus4  = pc + `DEC_XLEN'd4;
    assign br_offset = {{(`DEC_XLEN-18){imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    always_comb begin
        cond            = 1'b0;
        redirect.target = pc_plus4 + br_offset;    // beq/bne
        case (br_kind)
            BR_BEQ: cond = rs_eq_rt;
            BR_BNE: cond = !rs_eq_rt;
            BR_J, BR_JAL: begin
                cond            = 1'b1;
                redirect.target = {pc_plus4[`DEC_XLEN-1:`DEC_XLEN-4], jidx, 2'b00};
            end
            BR_JR: begin
                cond            = 1'b1;
                redirect.target = rs_value;
            end
            default: cond = 1'b0;
        endcase
    end

    // only redirect once the instruction actually leaves decode
    assign redirect.taken = fire && cond;

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_stage import decode_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       es_allowin,
    input  logic       fs_to_ds_valid,
    input  fetch_pkt_t fs_to_ds,
    input  wb_write_t  wb_write,
    input  fwd_src_t   es_fwd,
    input  fwd_src_t   ms_fwd,
    input  fwd_src_t   ws_fwd,
    output logic       ds_allowin,
    output logic       ds_to_es_valid,
    output issue_pkt_t ds_to_es,
    output redirect_t  redirect
);

    logic       ds_valid;
    logic       ds_ready_go;
    logic       stall;
    fetch_pkt_t fs_r;       // instruction held in decode
    dec_ctrl_t  ctrl;

    logic [`DEC_XLEN-1:0] rf_rdata1;
    logic [`DEC_XLEN-1:0] rf_rdata2;
    logic [`DEC_XLEN-1:0] rs_value;
    logic [`DEC_XLEN-1:0] rt_value;

    ////////////////////////////////////////////////////////////////////////////
    // valid/allowin handshake
    assign ds_ready_go    = !stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_r <= fs_to_ds;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode, operands, control flow
    inst_decoder u_dec (
        .inst (fs_r.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (fs_r.inst[25:21]),    // rs
        .rdata1 (rf_rdata1),
        .raddr2 (fs_r.inst[20:16]),    // rt
        .rdata2 (rf_rdata2),
        .wr     (wb_write)
    );

    operand_bypass u_bypass (
        .rs        (fs_r.inst[25:21]),
        .rt        (fs_r.inst[20:16]),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .br_kind  (ctrl.br_kind),
        .pc       (fs_r.pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .imm      (ctrl.imm),
        .jidx     (fs_r.inst[25:0]),
        .fire     (ds_to_es_valid),
        .redirect (redirect)
    );

    // packet to execute
    always_comb begin
        ds_to_es.alu_op       = ctrl.alu_op;
        ds_to_es.src1_is_sa   = ctrl.src1_is_sa;
        ds_to_es.src1_is_pc   = ctrl.src1_is_pc;
        ds_to_es.src2_is_imm  = ctrl.src2_is_imm;
        ds_to_es.src2_is_8    = ctrl.src2_is_8;
        ds_to_es.res_from_mem = ctrl.res_from_mem;
        ds_to_es.gr_we        = ctrl.gr_we;
        ds_to_es.mem_we       = ctrl.mem_we;
        ds_to_es.dest         = ctrl.dest;
        ds_to_es.imm          = ctrl.imm;
        ds_to_es.sa           = fs_r.inst[10:6];
        ds_to_es.rs_value     = rs_value;
        ds_to_es.rt_value     = rt_value;    // also store data for sw
        ds_to_es.pc           = fs_r.pc;
    end

endmodule

/* dv/decode_stage_tb.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_stage_tb import decode_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       es_allowin;
    logic       fs_to_ds_valid;
    fetch_pkt_t fs_to_ds;
    wb_write_t  wb_write;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    fwd_src_t   ws_fwd;
    logic       ds_allowin;
    logic       ds_to_es_valid;
    issue_pkt_t ds_to_es;
    redirect_t  redirect;

    logic [31:0] lcg_state = 32'h76b5;
    logic [31:0] rf_model [32];         // what the register file should hold
    logic [31:0] next_pc = 32'h0040_0000;

    decode_stage decode_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .es_allowin     (es_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .wb_write       (wb_write),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {`DEC_OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic fwd_src_t make_fwd(input logic wen, input logic is_load,
                                          input logic [4:0] dest, input logic [31:0] value);
        return {wen, is_load, dest, value};
    endfunction

    task automatic check(input string name, input logic [159:0] exp, input logic [159:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #2;     // inputs change here
    endtask

    // hands one instruction to decode and returns once it was taken
    task automatic present(input logic [31:0] pc, input logic [31:0] inst);
        int n;
        n = 0;
        do begin
            step();
            n++;
            if (n > 50) report_timeout("ds_allowin");
        end while (!ds_allowin);
        fs_to_ds_valid = 1'b1;
        fs_to_ds       = {pc, inst};
        step();
        fs_to_ds_valid = 1'b0;
        #1;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        #1;
        while (!ds_to_es_valid) begin
            step();
            #1;
            n++;
            if (n > 50) report_timeout("ds_to_es_valid");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    task automatic reset_test();
        #1;
        check("ds_to_es_valid", 0, ds_to_es_valid);
        check("redirect.taken", 0, redirect.taken);
        check("ds_allowin", 1, ds_allowin);
    endtask

    // flag order is src1_is_sa src1_is_pc src2_is_imm src2_is_8 res_from_mem gr_we mem_we
    task automatic expect_ctrl(input logic [31:0] inst, input alu_op_e op,
                               input logic [6:0] flags, input logic [4:0] dest);
        logic [31:0] pc;
        pc      = next_pc;
        next_pc = next_pc + 4;
        present(pc, inst);
        wait_issue();
        check("alu_op", op, ds_to_es.alu_op);
        check("ctrl flags", flags, {ds_to_es.src1_is_sa, ds_to_es.src1_is_pc,
                                    ds_to_es.src2_is_imm, ds_to_es.src2_is_8,
                                    ds_to_es.res_from_mem, ds_to_es.gr_we, ds_to_es.mem_we});
        check("dest", dest, ds_to_es.dest);
        check("imm", inst[15:0], ds_to_es.imm);
        check("sa", inst[10:6], ds_to_es.sa);
        check("pc", pc, ds_to_es.pc);
    endtask

    task automatic expect_noop(input logic [31:0] inst);
        present(next_pc, inst);
        wait_issue();
        check("gr_we", 0, ds_to_es.gr_we);
        check("mem_we", 0, ds_to_es.mem_we);
        check("redirect.taken", 0, redirect.taken);
    endtask

    task automatic decode_test();
        expect_ctrl(rtype(1, 2, 3, 0, `DEC_FN_ADDU), ALU_ADD, 7'b0000010, 5'd3);
        expect_ctrl(rtype(1, 2, 4, 0, `DEC_FN_SUBU), ALU_SUB, 7'b0000010, 5'd4);
        expect_ctrl(rtype(3, 4, 5, 0, `DEC_FN_SLT), ALU_SLT, 7'b0000010, 5'd5);
        expect_ctrl(rtype(3, 4, 6, 0, `DEC_FN_SLTU), ALU_SLTU, 7'b0000010, 5'd6);
        expect_ctrl(rtype(5, 6, 7, 0, `DEC_FN_AND), ALU_AND, 7'b0000010, 5'd7);
        expect_ctrl(rtype(5, 6, 8, 0, `DEC_FN_OR), ALU_OR, 7'b0000010, 5'd8);
        expect_ctrl(rtype(7, 8, 9, 0, `DEC_FN_XOR), ALU_XOR, 7'b0000010, 5'd9);
        expect_ctrl(rtype(7, 8, 10, 0, `DEC_FN_NOR), ALU_NOR, 7'b0000010, 5'd10);
        expect_ctrl(rtype(0, 2, 11, 4, `DEC_FN_SLL), ALU_SLL, 7'b1000010, 5'd11);
        expect_ctrl(rtype(0, 2, 12, 9, `DEC_FN_SRL), ALU_SRL, 7'b1000010, 5'd12);
        expect_ctrl(rtype(0, 2, 13, 31, `DEC_FN_SRA), ALU_SRA, 7'b1000010, 5'd13);
        expect_ctrl(itype(`DEC_OP_ADDIU, 1, 14, 16'h8123), ALU_ADD, 7'b0010010, 5'd14);
        expect_ctrl(itype(`DEC_OP_LUI, 0, 15, 16'h1234), ALU_LUI, 7'b0010010, 5'd15);
        expect_ctrl(itype(`DEC_OP_LW, 1, 16, 16'h0010), ALU_ADD, 7'b0010110, 5'd16);
        // sw writes no register so dest is the rd field of the offset
        expect_ctrl(itype(`DEC_OP_SW, 1, 17, 16'hfffc), ALU_ADD, 7'b0010001, 5'd31);
        expect_noop(itype(6'h3f, 1, 2, 16'h5555));          // reserved opcode
        expect_noop(rtype(1, 2, 3, 5'd1, `DEC_FN_ADDU));    // nonzero sa field
    endtask

    task automatic bypass_test();
        logic [31:0] v_ws;
        logic [31:0] v_ms;
        logic [31:0] v_es;
        rf_model[0] = '0;
        for (int r = 1; r < 32; r++) begin
            step();
            rf_model[r] = next_rand();
            wb_write    = {1'b1, r[4:0], rf_model[r]};
        end
        step();
        wb_write = {1'b1, 5'd0, next_rand()};   // must not stick in r0
        step();
        wb_write = '0;

        for (int r = 1; r < 32; r += 3) begin
            present(next_pc, rtype(r[4:0], 5'(32 - r), 5'd1, 0, `DEC_FN_ADDU));
            wait_issue();
            check("rs_value", rf_model[r], ds_to_es.rs_value);
            check("rt_value", rf_model[32-r], ds_to_es.rt_value);
        end

        // hold rs=5 rt=6 in decode and stack up sources on r5
        v_ws = next_rand();
        v_ms = next_rand();
        v_es = next_rand();
        step();
        es_allowin = 1'b0;
        present(next_pc, rtype(5, 6, 1, 0, `DEC_FN_ADDU));
        wait_issue();
        step();
        ws_fwd = make_fwd(1'b1, 1'b0, 5'd5, v_ws);
        #1;
        check("rs_value from ws", v_ws, ds_to_es.rs_value);
        step();
        ms_fwd = make_fwd(1'b1, 1'b0, 5'd5, v_ms);
        #1;
        check("rs_value from ms", v_ms, ds_to_es.rs_value);
        step();
        es_fwd = make_fwd(1'b1, 1'b0, 5'd5, v_es);
        #1;
        check("rs_value from es", v_es, ds_to_es.rs_value);
        check("rt_value", rf_model[6], ds_to_es.rt_value);
        step();
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        es_allowin = 1'b1;

        // r0 stays zero against every source
        step();
        es_allowin = 1'b0;
        es_fwd = make_fwd(1'b1, 1'b0, 5'd0, v_es);
        ws_fwd = make_fwd(1'b1, 1'b0, 5'd0, v_ws);
        present(next_pc, rtype(0, 0, 1, 0, `DEC_FN_ADDU));
        wait_issue();
        check("rs_value r0", 0, ds_to_es.rs_value);
        check("rt_value r0", 0, ds_to_es.rt_value);
        step();
        es_fwd = '0;
        ws_fwd = '0;
        es_allowin = 1'b1;
    endtask

    task automatic stall_test();
        logic [31:0] v_load;
        v_load = next_rand();
        step();
        es_fwd = make_fwd(1'b1, 1'b1, 5'd5, 32'hdead_beef);
        present(next_pc, rtype(5, 6, 11, 0, `DEC_FN_ADDU));
        for (int i = 0; i < 3; i++) begin
            check("ds_to_es_valid stalled", 0, ds_to_es_valid);
            check("ds_allowin stalled", 0, ds_allowin);
            step();
        end
        es_fwd = '0;
        ms_fwd = make_fwd(1'b1, 1'b1, 5'd5, 32'hdead_beef);     // load moved to ms
        #1;
        check("ds_to_es_valid stalled", 0, ds_to_es_valid);
        check("ds_allowin stalled", 0, ds_allowin);
        step();
        ms_fwd = '0;
        ws_fwd = make_fwd(1'b1, 1'b0, 5'd5, v_load);
        wait_issue();
        check("rs_value after load", v_load, ds_to_es.rs_value);
        check("rt_value", rf_model[6], ds_to_es.rt_value);
        step();
        ws_fwd = '0;

        // load on rt in ms
        ms_fwd = make_fwd(1'b1, 1'b1, 5'd6, 32'h0);
        present(next_pc, rtype(5, 6, 11, 0, `DEC_FN_ADDU));
        check("ds_to_es_valid stalled", 0, ds_to_es_valid);
        step();
        ms_fwd = '0;
        wait_issue();

        // unrelated load issues one cycle after acceptance
        step();
        es_fwd = make_fwd(1'b1, 1'b1, 5'd12, 32'h0);
        present(next_pc, rtype(5, 6, 11, 0, `DEC_FN_ADDU));
        check("ds_to_es_valid", 1, ds_to_es_valid);
        check("rs_value", rf_model[5], ds_to_es.rs_value);
        step();
        es_fwd = '0;
    endtask

    function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [15:0] imm);
        return pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] pc, input logic [25:0] idx);
        logic [31:0] pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], idx, 2'b00};
    endfunction

    task automatic expect_redirect(input logic [31:0] pc, input logic [31:0] inst,
                                   input logic taken, input logic [31:0] target);
        present(pc, inst);
        wait_issue();
        check("redirect.taken", taken, redirect.taken);
        if (taken) check("redirect.target", target, redirect.target);
    endtask

    task automatic branch_test();
        logic [31:0] pc;
        pc = 32'h0040_1000;
        expect_redirect(pc, itype(`DEC_OP_BEQ, 5, 5, 16'h0010), 1'b1,
                        branch_target(pc, 16'h0010));
        expect_redirect(pc, itype(`DEC_OP_BEQ, 5, 6, 16'hfffc), rf_model[5] == rf_model[6],
                        branch_target(pc, 16'hfffc));
        expect_redirect(pc, itype(`DEC_OP_BNE, 5, 6, 16'h0020), rf_model[5] != rf_model[6],
                        branch_target(pc, 16'h0020));
        expect_redirect(pc, itype(`DEC_OP_BNE, 7, 7, 16'h0020), 1'b0, 32'h0);
        pc = 32'h9000_0ffc;     // pc+4 crosses into the next 4 KB
        expect_redirect(pc, jtype(`DEC_OP_J, 26'h0123456), 1'b1,
                        jump_target(pc, 26'h0123456));
        expect_redirect(pc, jtype(`DEC_OP_JAL, 26'h3ffffff), 1'b1,
                        jump_target(pc, 26'h3ffffff));
        check("jal dest", 31, ds_to_es.dest);
        check("jal gr_we", 1, ds_to_es.gr_we);
        check("jal src1_is_pc", 1, ds_to_es.src1_is_pc);
        check("jal src2_is_8", 1, ds_to_es.src2_is_8);
        expect_redirect(pc, rtype(7, 0, 0, 0, `DEC_FN_JR), 1'b1, rf_model[7]);
        step();
        #1;
        check("redirect.taken when empty", 0, redirect.taken);
    endtask

    task automatic backpressure_test();
        issue_pkt_t held;
        logic [31:0] pc_b;
        step();
        es_allowin = 1'b0;
        present(32'h0050_0000, rtype(1, 2, 12, 0, `DEC_FN_OR));
        check("held pc", 32'h0050_0000, ds_to_es.pc);
        held = ds_to_es;
        for (int i = 0; i < 4; i++) begin
            step();
            fs_to_ds_valid = 1'b1;
            fs_to_ds       = {next_rand(), next_rand()};   // must be ignored
            #1;
            check("ds_to_es held", held, ds_to_es);
            check("ds_allowin", 0, ds_allowin);
            check("ds_to_es_valid", 1, ds_to_es_valid);
        end
        pc_b = 32'h0050_0004;
        step();
        es_allowin = 1'b1;
        fs_to_ds   = {pc_b, rtype(3, 4, 13, 0, `DEC_FN_AND)};
        #1;
        check("ds_to_es held", held, ds_to_es);
        check("ds_to_es_valid", 1, ds_to_es_valid);
        step();
        fs_to_ds_valid = 1'b0;
        #1;
        check("next pc", pc_b, ds_to_es.pc);
        check("ds_to_es_valid", 1, ds_to_es_valid);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reset          = 1'b1;
        es_allowin     = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds       = '0;
        wb_write       = '0;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_fwd         = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        reset_test();
        bypass_test();      // fills the register file for the later tests
        decode_test();
        stall_test();
        branch_test();
        backpressure_test();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
dv/decode_stage_tb.sv
